// ==== hdl/meas_config.svh ====
`ifndef MEAS_CONFIG_SVH
`define MEAS_CONFIG_SVH

////////////////////////////////////////
// clocking and serial line
////////////////////////////////////////

// system clock in Hz
`define MEAS_CLK_HZ 10000000
// uart line rate
`define MEAS_BAUD 115200
// rounded to nearest, 87 at 10 MHz
`define MEAS_CLKS_PER_BIT ((`MEAS_CLK_HZ + (`MEAS_BAUD / 2)) / `MEAS_BAUD)

////////////////////////////////////////
// command and reply framing
////////////////////////////////////////

`define MEAS_FRAME_BYTES 8
`define MEAS_FRAME_HEAD 8'hA5
`define MEAS_FRAME_TAIL 8'hEC
`define MEAS_REPLY_HEAD 8'h5A

// shortest gate in system clocks
`define MEAS_GATE_CYCLES 2000
`define MEAS_CNT_W 32

`endif

// ==== hdl/meas_pkg.sv ====
package meas_pkg;

    // shared by receiver and transmitter
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

    // command controller states
    typedef enum logic [2:0] {
        CTRL_RECV,
        CTRL_DECODE,
        CTRL_MEASURE,
        CTRL_SEND,
        CTRL_ERR
    } ctrl_state_t;

    // opcode field, bytes 1 to 6 of the frame
    typedef enum logic [47:0] {
        OP_FREQ = 48'd1
    } opcode_t;

endpackage

// ==== hdl/uart_rx.sv ====
`include "meas_config.svh"

module uart_rx (
    input  logic       I_sys_clk,
    input  logic       I_rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int CPB = `MEAS_CLKS_PER_BIT;
    localparam int CW = $clog2(CPB);
    localparam logic [CW-1:0] BIT_LAST = CW'(CPB - 1);
    localparam logic [CW-1:0] BIT_HALF = CW'(CPB / 2 - 1);

    meas_pkg::uart_state_t state;
    logic [1:0]    rx_sync;
    logic          rx_prev;
    logic [CW-1:0] bit_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift_reg;
    logic          rx_fall;

    // line idles high, so sync flops reset high
    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_sync[1];
        end
    end

    assign rx_fall = rx_prev & ~rx_sync[1];

    ////////////////////////////////////////
    // bit sampling FSM
    ////////////////////////////////////////

    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            state    <= meas_pkg::UART_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                meas_pkg::UART_IDLE: begin
                    bit_cnt <= '0;
                    if (rx_fall) begin
                        state <= meas_pkg::UART_START;
                    end
                end
                meas_pkg::UART_START: begin
                    // mid start bit, glitch check
                    if (bit_cnt == BIT_HALF) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync[1] ? meas_pkg::UART_IDLE : meas_pkg::UART_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                meas_pkg::UART_DATA: begin
                    if (bit_cnt == BIT_LAST) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= meas_pkg::UART_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    // stop bit must be high or the byte is lost
                    if (bit_cnt == BIT_LAST) begin
                        bit_cnt  <= '0;
                        rx_valid <= rx_sync[1];
                        state    <= meas_pkg::UART_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge I_sys_clk) begin
        if (state == meas_pkg::UART_DATA && bit_cnt == BIT_LAST) begin
            shift_reg <= {rx_sync[1], shift_reg[7:1]};
        end
        if (state == meas_pkg::UART_STOP && bit_cnt == BIT_LAST) begin
            rx_data <= shift_reg;
        end
    end

    // one byte per frame time, never back to back
    a_valid_pulse: assert property (
        @(posedge I_sys_clk) disable iff (!I_rst_n)
        rx_valid |=> !rx_valid
    );

endmodule

// ==== hdl/uart_tx.sv ====
`include "meas_config.svh"

module uart_tx (
    input  logic       I_sys_clk,
    input  logic       I_rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       tx
);

    localparam int CPB = `MEAS_CLKS_PER_BIT;
    localparam int CW = $clog2(CPB);
    localparam logic [CW-1:0] BIT_LAST = CW'(CPB - 1);

    meas_pkg::uart_state_t state;
    logic [CW-1:0] bit_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift_reg;
    logic          bit_end;

    // last cycle of the current bit
    assign bit_end = (bit_cnt == BIT_LAST);

    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            state   <= meas_pkg::UART_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_busy <= 1'b0;
            tx      <= 1'b1;
        end else begin
            bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
            case (state)
                meas_pkg::UART_IDLE: begin
                    bit_cnt <= '0;
                    if (tx_start) begin
                        // start bit on the next cycle
                        tx      <= 1'b0;
                        tx_busy <= 1'b1;
                        state   <= meas_pkg::UART_START;
                    end
                end
                meas_pkg::UART_START: begin
                    if (bit_end) begin
                        tx      <= shift_reg[0];
                        bit_idx <= '0;
                        state   <= meas_pkg::UART_DATA;
                    end
                end
                meas_pkg::UART_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        // after bit 7 comes the stop bit
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= meas_pkg::UART_STOP;
                        end else begin
                            tx <= shift_reg[bit_idx + 1'b1];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        tx_busy <= 1'b0;
                        state   <= meas_pkg::UART_IDLE;
                    end
                end
            endcase
        end
    end

    // byte held for the whole frame
    always_ff @(posedge I_sys_clk) begin
        if (state == meas_pkg::UART_IDLE && tx_start) begin
            shift_reg <= tx_data;
        end
    end

    // the controller must wait out a busy transmitter
    a_start_idle: assert property (
        @(posedge I_sys_clk) disable iff (!I_rst_n)
        tx_start |-> !tx_busy
    );

endmodule

// ==== hdl/freq_counter.sv ====
`include "meas_config.svh"

module freq_counter (
    input  logic                   I_sys_clk,
    input  logic                   I_rst_n,
    input  logic                   fx_clk,
    input  logic                   start,
    output logic                   done,
    output logic [`MEAS_CNT_W-1:0] f0_cnt,
    output logic [`MEAS_CNT_W-1:0] fx_cnt
);

    // gate may close once the clock count reaches this
    localparam logic [`MEAS_CNT_W-1:0] GATE_LAST = `MEAS_GATE_CYCLES - 1;

    logic [1:0]             fx_sync;
    logic                   fx_prev;
    logic                   fx_rise;
    logic                   armed;
    logic                   gate_on;
    logic [`MEAS_CNT_W-1:0] f0_run;
    logic [`MEAS_CNT_W-1:0] fx_run;
    logic                   gate_close;

    // fx is asynchronous to the system clock
    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            fx_sync <= 2'b00;
            fx_prev <= 1'b0;
        end else begin
            fx_sync <= {fx_sync[0], fx_clk};
            fx_prev <= fx_sync[1];
        end
    end

    assign fx_rise = fx_sync[1] & ~fx_prev;
    // f0_run doubles as the gate timer
    assign gate_close = gate_on && fx_rise && (f0_run >= GATE_LAST);

    ////////////////////////////////////////
    // gate control
    ////////////////////////////////////////

    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            armed   <= 1'b0;
            gate_on <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= gate_close;
            if (start) begin
                armed   <= 1'b1;
                gate_on <= 1'b0;
            end else if (armed && fx_rise) begin
                // open on an fx edge
                armed   <= 1'b0;
                gate_on <= 1'b1;
            end else if (gate_close) begin
                gate_on <= 1'b0;
            end
        end
    end

    // running counts, cleared at the opening edge
    always_ff @(posedge I_sys_clk) begin
        if (armed && fx_rise) begin
            f0_run <= '0;
            fx_run <= '0;
        end else if (gate_on) begin
            f0_run <= f0_run + 1'b1;
            fx_run <= fx_run + fx_rise;
        end
        // closing edge counted in both
        if (gate_close) begin
            f0_cnt <= f0_run + 1'b1;
            fx_cnt <= fx_run + 1'b1;
        end
    end

    // no second done without a fresh start
    a_done_after_start: assert property (
        @(posedge I_sys_clk) disable iff (!I_rst_n)
        done |=> (!done until start)
    );

endmodule

// ==== hdl/cmd_ctrl.sv ====
`include "meas_config.svh"

module cmd_ctrl (
    input  logic                   I_sys_clk,
    input  logic                   I_rst_n,
    input  logic [7:0]             rx_data,
    input  logic                   rx_valid,
    output logic [7:0]             tx_data,
    output logic                   tx_start,
    input  logic                   tx_busy,
    output logic                   meas_start,
    input  logic                   meas_done,
    input  logic [`MEAS_CNT_W-1:0] f0_cnt,
    input  logic [`MEAS_CNT_W-1:0] fx_cnt,
    output logic                   led_n
);

    localparam int FRAME_W = `MEAS_FRAME_BYTES * 8;
    localparam int REPLY_BYTES = 1 + 2 * (`MEAS_CNT_W / 8);
    localparam int REPLY_W = REPLY_BYTES * 8;
    // partial frame dropped after 20 silent bit times
    localparam int TIMEOUT = 20 * `MEAS_CLKS_PER_BIT;
    localparam int TW = $clog2(TIMEOUT);
    localparam int BW = $clog2(`MEAS_FRAME_BYTES);
    localparam logic [BW-1:0] BYTE_LAST = BW'(`MEAS_FRAME_BYTES - 1);
    localparam logic [TW-1:0] IDLE_LAST = TW'(TIMEOUT - 1);

    meas_pkg::ctrl_state_t state;
    logic [FRAME_W-1:0] frame;
    logic [BW-1:0]      byte_cnt;
    logic [TW-1:0]      idle_cnt;
    logic [REPLY_W-1:0] reply_sr;
    logic [3:0]         bytes_left;
    logic               frame_ok;
    logic               tx_ready;

    // byte 0 head, byte 7 tail, opcode between them lsb first
    assign frame_ok = (frame[7:0] == `MEAS_FRAME_HEAD)
                   && (frame[FRAME_W-1 -: 8] == `MEAS_FRAME_TAIL)
                   && (meas_pkg::opcode_t'(frame[FRAME_W-9:8]) == meas_pkg::OP_FREQ);

    // hold off while a start is in flight
    assign tx_ready = !tx_busy && !tx_start;

    ////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////

    always_ff @(posedge I_sys_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            state      <= meas_pkg::CTRL_RECV;
            byte_cnt   <= '0;
            idle_cnt   <= '0;
            bytes_left <= '0;
            tx_start   <= 1'b0;
            meas_start <= 1'b0;
            led_n      <= 1'b1;
        end else begin
            tx_start   <= 1'b0;
            meas_start <= 1'b0;
            case (state)
                meas_pkg::CTRL_RECV: begin
                    if (rx_valid) begin
                        idle_cnt <= '0;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == BYTE_LAST) begin
                            state <= meas_pkg::CTRL_DECODE;
                        end
                    end else if (byte_cnt != '0) begin
                        // inter-byte gap watch
                        if (idle_cnt == IDLE_LAST) begin
                            idle_cnt <= '0;
                            byte_cnt <= '0;
                        end else begin
                            idle_cnt <= idle_cnt + 1'b1;
                        end
                    end
                end
                meas_pkg::CTRL_DECODE: begin
                    if (frame_ok) begin
                        led_n      <= 1'b1;
                        meas_start <= 1'b1;
                        state      <= meas_pkg::CTRL_MEASURE;
                    end else begin
                        state <= meas_pkg::CTRL_ERR;
                    end
                end
                meas_pkg::CTRL_MEASURE: begin
                    if (meas_done) begin
                        bytes_left <= 4'(REPLY_BYTES);
                        state      <= meas_pkg::CTRL_SEND;
                    end
                end
                meas_pkg::CTRL_SEND: begin
                    if (tx_ready) begin
                        tx_start   <= 1'b1;
                        bytes_left <= bytes_left - 1'b1;
                        // last byte handed over, back to listening
                        if (bytes_left == 4'd1) begin
                            state <= meas_pkg::CTRL_RECV;
                        end
                    end
                end
                default: begin
                    // bad frame, led held low until a good one
                    led_n <= 1'b0;
                    state <= meas_pkg::CTRL_RECV;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // frame and reply data
    ////////////////////////////////////////

    always_ff @(posedge I_sys_clk) begin
        // newest byte enters at the top
        if (state == meas_pkg::CTRL_RECV && rx_valid) begin
            frame <= {rx_data, frame[FRAME_W-1:8]};
        end
        if (state == meas_pkg::CTRL_MEASURE && meas_done) begin
            reply_sr <= {fx_cnt, f0_cnt, `MEAS_REPLY_HEAD};
        end else if (state == meas_pkg::CTRL_SEND && tx_ready) begin
            tx_data  <= reply_sr[7:0];
            reply_sr <= reply_sr >> 8;
        end
    end

    // one start per measurement, none until it reports done
    a_start_pulse: assert property (
        @(posedge I_sys_clk) disable iff (!I_rst_n)
        meas_start |=> (!meas_start until meas_done)
    );

endmodule

// ==== hdl/meas_top.sv ====
`include "meas_config.svh"

module meas_top (
    input  logic I_sys_clk,
    input  logic I_rst_n,
    input  logic fx_clk,
    input  logic uart_rx,
    output logic uart_tx,
    output logic led_n
);

    logic [7:0]             rx_data;
    logic                   rx_valid;
    logic [7:0]             tx_data;
    logic                   tx_start;
    logic                   tx_busy;
    logic                   meas_start;
    logic                   meas_done;
    logic [`MEAS_CNT_W-1:0] f0_cnt;
    logic [`MEAS_CNT_W-1:0] fx_cnt;

    // host command path
    uart_rx u_uart_rx (
        .I_sys_clk (I_sys_clk),
        .I_rst_n   (I_rst_n),
        .rx        (uart_rx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)
    );

    // reply path
    uart_tx u_uart_tx (
        .I_sys_clk (I_sys_clk),
        .I_rst_n   (I_rst_n),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .tx        (uart_tx)
    );

    freq_counter u_freq_counter (
        .I_sys_clk (I_sys_clk),
        .I_rst_n   (I_rst_n),
        .fx_clk    (fx_clk),
        .start     (meas_start),
        .done      (meas_done),
        .f0_cnt    (f0_cnt),
        .fx_cnt    (fx_cnt)
    );

    cmd_ctrl u_cmd_ctrl (
        .I_sys_clk  (I_sys_clk),
        .I_rst_n    (I_rst_n),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .tx_busy    (tx_busy),
        .meas_start (meas_start),
        .meas_done  (meas_done),
        .f0_cnt     (f0_cnt),
        .fx_cnt     (fx_cnt),
        .led_n      (led_n)
    );

endmodule

// ==== test/clk_gen.sv ====
module clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic I_sys_clk,
    output logic I_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // free running system clock
    initial begin
        I_sys_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) I_sys_clk = ~I_sys_clk;
        end
    end

    // reset held low, released on a rising edge
    initial begin
        I_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge I_sys_clk);
        I_rst_n <= 1'b1;
    end

endmodule

// ==== test/tb_meas_top.sv ====
`include "meas_config.svh"

module tb_meas_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS = 1000000000 / `MEAS_CLK_HZ;
    localparam int CPB = `MEAS_CLKS_PER_BIT;
    localparam int GATE = `MEAS_GATE_CYCLES;
    localparam int P_MAX = 40;
    // slowest gate plus nine reply bytes, with room
    localparam int REPLY_WAIT = GATE + 3 * P_MAX + 110 * CPB;
    // listening window after a bad frame
    localparam int QUIET_WAIT = GATE + 30 * CPB;
    // ten 9-byte frames, three slow gates, margin
    localparam longint WATCHDOG_NS =
        (longint'(10 * 9 * 10 + 300) * CPB + 3 * (GATE + 2 * P_MAX)) * CLK_NS;

    logic       I_sys_clk;
    logic       I_rst_n;
    logic       fx_clk;
    logic       uart_rx;
    logic       uart_tx;
    logic       led_n;
    int         fx_period;
    int         fx_phase;
    logic       tx_quiet;
    logic       led_check;
    logic       led_expect;
    logic [7:0] reply_q[$];
    int         value_errors;
    int         protocol_errors;

    clk_gen #(
        .PERIOD_NS    (CLK_NS),
        .RESET_CYCLES (4)
    ) u_clk_gen (
        .I_sys_clk (I_sys_clk),
        .I_rst_n   (I_rst_n)
    );

    meas_top UUT (
        .I_sys_clk (I_sys_clk),
        .I_rst_n   (I_rst_n),
        .fx_clk    (fx_clk),
        .uart_rx   (uart_rx),
        .uart_tx   (uart_tx),
        .led_n     (led_n)
    );

    ////////////////////////////////////////
    // fx source and line checks
    ////////////////////////////////////////

    // fx period of fx_period system clocks, high for the first half
    always @(posedge I_sys_clk) begin
        if (fx_phase >= fx_period - 1) begin
            fx_phase <= 0;
        end else begin
            fx_phase <= fx_phase + 1;
        end
        fx_clk <= (fx_phase < fx_period / 2);
    end

    // no start bit while no reply is due
    a_tx_quiet: assert property (
        @(posedge I_sys_clk) disable iff (!I_rst_n)
        tx_quiet |-> uart_tx
    ) else begin
        protocol_errors++;
        $display("uart_tx left idle while no reply was expected at %0t", $time);
    end

    // error led level while a test holds it fixed
    a_led_level: assert property (
        @(posedge I_sys_clk) disable iff (!I_rst_n)
        led_check |-> (led_n == led_expect)
    ) else begin
        value_errors++;
        $display("[ERROR] led_level: expected %0b, actual %0b",
                 $sampled(led_expect), $sampled(led_n));
    end

    // reply decoder, samples on the falling edge
    initial begin : reply_monitor
        logic [7:0] rx_byte;
        forever begin
            @(negedge I_sys_clk);
            if (I_rst_n === 1'b1 && uart_tx === 1'b0) begin
                // middle of the start bit
                repeat (CPB / 2) @(negedge I_sys_clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge I_sys_clk);
                    rx_byte[i] = uart_tx;
                end
                repeat (CPB) @(negedge I_sys_clk);
                if (uart_tx === 1'b1) begin
                    reply_q.push_back(rx_byte);
                end else begin
                    protocol_errors++;
                    $display("reply byte had a low stop bit at %0t", $time);
                end
            end
        end
    end

    ////////////////////////////////////////
    // tasks
    ////////////////////////////////////////

    task automatic check_equal(input string name, input longint expected, input longint actual);
        assert (actual == expected)
        else begin
            value_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_at_least(input string name, input longint lower, input longint actual);
        assert (actual >= lower)
        else begin
            value_errors++;
            $display("[ERROR] %s: expected at least %0d, actual %0d", name, lower, actual);
        end
    endtask

    // 8N1, lsb first, each bit CPB clocks
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        @(posedge I_sys_clk);
        for (int i = 0; i < 10; i++) begin
            uart_rx <= bits[i];
            repeat (CPB) @(posedge I_sys_clk);
        end
    endtask

    task automatic send_frame(input logic [7:0] head, input logic [47:0] opcode,
                              input logic [7:0] tail);
        send_byte(head);
        for (int i = 0; i < 6; i++) begin
            send_byte(opcode[8*i +: 8]);
        end
        send_byte(tail);
    endtask

    task automatic wait_reply_bytes(input string name, input int count);
        int waited;
        waited = 0;
        while (reply_q.size() < count && waited < REPLY_WAIT) begin
            @(posedge I_sys_clk);
            waited++;
        end
        if (reply_q.size() < count) begin
            protocol_errors++;
            $display("%s: reply timed out with %0d of %0d bytes", name, reply_q.size(), count);
        end
    endtask

    // one measurement at fx period p, then the reply rules
    task automatic run_freq_test(input string name, input int p);
        longint f0;
        longint fx;
        fx_period <= p;
        repeat (2 * P_MAX) @(posedge I_sys_clk);
        reply_q.delete();
        send_frame(`MEAS_FRAME_HEAD, 48'(meas_pkg::OP_FREQ), `MEAS_FRAME_TAIL);
        wait_reply_bytes(name, 9);
        // extra bytes would show up here
        repeat (20 * CPB) @(posedge I_sys_clk);
        @(negedge I_sys_clk);
        check_equal({name, " byte count"}, 9, reply_q.size());
        if (reply_q.size() >= 9) begin
            f0 = {reply_q[4], reply_q[3], reply_q[2], reply_q[1]};
            fx = {reply_q[8], reply_q[7], reply_q[6], reply_q[5]};
            check_equal({name, " head"}, `MEAS_REPLY_HEAD, reply_q[0]);
            check_at_least({name, " fx_cnt"}, 1, fx);
            check_at_least({name, " f0_cnt"}, GATE, f0);
            check_equal({name, " f0_cnt vs fx_cnt*P"}, fx * p, f0);
        end
        check_equal({name, " led_n"}, 1, led_n);
        reply_q.delete();
    endtask

    // bad frame, no reply and led low afterwards
    task automatic expect_no_reply(input string name, input logic [7:0] head,
                                   input logic [47:0] opcode, input logic [7:0] tail);
        reply_q.delete();
        tx_quiet <= 1'b1;
        send_frame(head, opcode, tail);
        repeat (QUIET_WAIT) @(posedge I_sys_clk);
        @(negedge I_sys_clk);
        check_equal({name, " byte count"}, 0, reply_q.size());
        check_equal({name, " led_n"}, 0, led_n);
        @(posedge I_sys_clk);
        tx_quiet <= 1'b0;
    endtask

    task automatic print_counts();
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin : stimulus
        int p1;
        int p2;
        logic [7:0] bad_head;
        void'($urandom(32'hfe4ce6aa));
        uart_rx = 1'b1;
        fx_clk = 1'b0;
        fx_period = 10;
        fx_phase = 0;
        tx_quiet = 1'b0;
        led_check = 1'b0;
        led_expect = 1'b1;
        value_errors = 0;
        protocol_errors = 0;
        @(posedge I_rst_n);
        @(posedge I_sys_clk);
        // idle line after reset
        tx_quiet <= 1'b1;
        led_check <= 1'b1;
        repeat (20 * CPB) @(posedge I_sys_clk);
        @(negedge I_sys_clk);
        check_equal("reset byte count", 0, reply_q.size());
        @(posedge I_sys_clk);
        tx_quiet <= 1'b0;
        // two measurements, distinct periods
        p1 = 3 + int'($urandom % 38);
        run_freq_test("freq_p1", p1);
        do begin
            p2 = 3 + int'($urandom % 38);
        end while (p2 == p1);
        run_freq_test("freq_p2", p2);
        // led drops on a bad frame
        led_check <= 1'b0;
        do begin
            bad_head = 8'($urandom);
        end while (bad_head == `MEAS_FRAME_HEAD);
        expect_no_reply("bad_head", bad_head, 48'(meas_pkg::OP_FREQ), `MEAS_FRAME_TAIL);
        expect_no_reply("bad_tail", `MEAS_FRAME_HEAD, 48'(meas_pkg::OP_FREQ), ~`MEAS_FRAME_TAIL);
        // old display test opcode, led must stay low
        led_expect <= 1'b0;
        led_check <= 1'b1;
        expect_no_reply("op_display", `MEAS_FRAME_HEAD, 48'd2, `MEAS_FRAME_TAIL);
        led_check <= 1'b0;
        run_freq_test("freq_recover", p1);
        print_counts();
        if (value_errors + protocol_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        print_counts();
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/meas_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/freq_counter.sv
hdl/cmd_ctrl.sv
hdl/meas_top.sv
test/clk_gen.sv
test/tb_meas_top.sv

// ==== Bender.yml ====
package:
  name: meas_top

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/meas_pkg.sv
      - hdl/uart_rx.sv
      - hdl/uart_tx.sv
      - hdl/freq_counter.sv
      - hdl/cmd_ctrl.sv
      - hdl/meas_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/clk_gen.sv
      - test/tb_meas_top.sv
